/* Makefile */
VERILATOR = verilator
TOP       = tb_nasti_lite_writer
FILELIST  = files.f
FLAGS     = --timing --assert
SIM_FLAGS = --binary -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axi_pkg.sv */
// protocol types of the nasti write channels, shared by the bridge and its testbench
`default_nettype none
`include "bridge_params.svh"

package axi_pkg;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_exokay = 2'b01,
      resp_slverr = 2'b10,
      resp_decerr = 2'b11
   } resp_t;

   typedef enum logic [1:0] {
      burst_fixed = 2'b00,
      burst_incr  = 2'b01,
      burst_wrap  = 2'b10
   } burst_t;

   localparam int lite_per_beat = `NASTI_DATA_WIDTH / `LITE_DATA_WIDTH;

   // one w beat, seen whole or as lite words, low word first
   typedef union packed {
      logic [`NASTI_DATA_WIDTH-1:0]                      whole;
      logic [lite_per_beat-1:0][`LITE_DATA_WIDTH-1:0]    word;
   } beat_u;

   typedef union packed {
      logic [`NASTI_DATA_WIDTH/8-1:0]                    whole;
      logic [lite_per_beat-1:0][`LITE_DATA_WIDTH/8-1:0]  half;
   } beat_strb_u;

endpackage
`default_nettype wire

/* bridge_params.svh */
// widths and depths of the nasti to nasti-lite write bridge, included by rtl and testbench
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// transaction id bits
`define ID_WIDTH 2

// byte address on both ports
`define ADDR_WIDTH 16

// full-width beat on the nasti slave port
`define NASTI_DATA_WIDTH 64

// single word on the lite master port
`define LITE_DATA_WIDTH 32

// outstanding bursts, one response slot each
`define MAX_XACT 4

// lite pieces held between nasti w and lite aw/w, two beats
`define BUF_DEPTH 4

`endif

/* bridge_pkg.sv */
// bridge-internal types and the response merge rule, used by the slot and merger modules
`default_nettype none
`include "bridge_params.svh"

package bridge_pkg;

   typedef logic [$clog2(`MAX_XACT)-1:0] slot_idx_t;

   // 256 beats of two pieces, so 512 must fit
   typedef logic [9:0] piece_cnt_t;

   // larger code is the more severe one
   function automatic axi_pkg::resp_t merge_resp(axi_pkg::resp_t a, axi_pkg::resp_t b);
      return (b > a) ? b : a;
   endfunction

endpackage
`default_nettype wire

/* burst_splitter.sv */
// takes nasti aw and w beats and issues each beat as two lite writes, used inside the bridge top
`default_nettype none
`include "bridge_params.svh"

module burst_splitter (
   input  wire                             clk,
   input  wire                             rstn,
   input  wire [`ID_WIDTH-1:0]             nasti_aw_id,
   input  wire [`ADDR_WIDTH-1:0]           nasti_aw_addr,
   input  wire [7:0]                       nasti_aw_len,
   input  wire [2:0]                       nasti_aw_size,
   input  wire axi_pkg::burst_t            nasti_aw_burst,
   input  wire [2:0]                       nasti_aw_prot,
   input  wire [3:0]                       nasti_aw_qos,
   input  wire [3:0]                       nasti_aw_region,
   input  wire                             nasti_aw_valid,
   output logic                            nasti_aw_ready,
   input  wire axi_pkg::beat_u             nasti_w_data,
   input  wire axi_pkg::beat_strb_u        nasti_w_strb,
   input  wire                             nasti_w_last,
   input  wire                             nasti_w_valid,
   output logic                            nasti_w_ready,
   output logic [`ID_WIDTH-1:0]            lite_aw_id,
   output logic [`ADDR_WIDTH-1:0]          lite_aw_addr,
   output logic [2:0]                      lite_aw_prot,
   output logic [3:0]                      lite_aw_qos,
   output logic [3:0]                      lite_aw_region,
   output logic                            lite_aw_valid,
   input  wire                             lite_aw_ready,
   output logic [`LITE_DATA_WIDTH-1:0]     lite_w_data,
   output logic [`LITE_DATA_WIDTH/8-1:0]   lite_w_strb,
   output logic                            lite_w_valid,
   input  wire                             lite_w_ready,
   input  wire                             aw_ok,
   output logic                            xact_start,
   output logic [`ID_WIDTH-1:0]            xact_id,
   output logic                            pieces_add,
   output logic                            pieces_last
);
   import axi_pkg::*;

   localparam int ptr_w = $clog2(`BUF_DEPTH);

   logic                                        lock, last_done;
   logic [`ADDR_WIDTH-1:0]                      beat_addr;
   logic [7:0]                                  aw_len, beat_cnt;
   logic [ptr_w-1:0]                            wp, wp_hi, aw_rp, w_rp;
   logic [`BUF_DEPTH-1:0]                       aw_q_valid, w_q_valid;
   logic [`BUF_DEPTH-1:0][`ADDR_WIDTH-1:0]      addr_q;
   logic [`BUF_DEPTH-1:0][`LITE_DATA_WIDTH-1:0] data_q;
   logic [`BUF_DEPTH-1:0][`LITE_DATA_WIDTH/8-1:0] strb_q;
   logic                                        aw_fire, w_fire, la_fire, lw_fire;
   logic                                        pair_free, drained;

   assign wp_hi = wp + ptr_w'(1);   // wp is always even
   assign pair_free = !aw_q_valid[wp] && !aw_q_valid[wp_hi] && !w_q_valid[wp] && !w_q_valid[wp_hi];
   assign drained = !(|aw_q_valid) && !(|w_q_valid);

   assign nasti_aw_ready = !lock && aw_ok;
   assign nasti_w_ready = lock && !last_done && pair_free;
   assign aw_fire = nasti_aw_valid && nasti_aw_ready;
   assign w_fire = nasti_w_valid && nasti_w_ready;
   assign la_fire = lite_aw_valid && lite_aw_ready;
   assign lw_fire = lite_w_valid && lite_w_ready;

   assign xact_start = aw_fire;
   assign xact_id = nasti_aw_id;
   assign pieces_add = w_fire;
   assign pieces_last = nasti_w_last;

   assign lite_aw_addr = addr_q[aw_rp];
   assign lite_aw_valid = aw_q_valid[aw_rp];
   assign lite_w_data = data_q[w_rp];
   assign lite_w_strb = strb_q[w_rp];
   assign lite_w_valid = w_q_valid[w_rp];

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         lock <= 1'b0;
         last_done <= 1'b0;
         beat_cnt <= '0;
         wp <= '0;
         aw_rp <= '0;
         w_rp <= '0;
         aw_q_valid <= '0;
         w_q_valid <= '0;
      end else begin
         if (aw_fire) begin
            lock <= 1'b1;
            beat_cnt <= '0;
         end else if (last_done && drained) begin
            lock <= 1'b0;   // burst fully handed to lite side
            last_done <= 1'b0;
         end
         if (w_fire) begin
            beat_cnt <= beat_cnt + 8'd1;
            last_done <= nasti_w_last;
            wp <= wp + ptr_w'(2);
            aw_q_valid[wp] <= 1'b1;
            aw_q_valid[wp_hi] <= 1'b1;
            w_q_valid[wp] <= 1'b1;
            w_q_valid[wp_hi] <= 1'b1;
         end
         if (la_fire) begin
            aw_rp <= aw_rp + ptr_w'(1);
            aw_q_valid[aw_rp] <= 1'b0;
         end
         if (lw_fire) begin
            w_rp <= w_rp + ptr_w'(1);
            w_q_valid[w_rp] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         lite_aw_id <= nasti_aw_id;
         lite_aw_prot <= nasti_aw_prot;
         lite_aw_qos <= nasti_aw_qos;
         lite_aw_region <= nasti_aw_region;
         aw_len <= nasti_aw_len;
         beat_addr <= nasti_aw_addr;
      end else if (w_fire) begin
         beat_addr <= beat_addr + `ADDR_WIDTH'(`NASTI_DATA_WIDTH/8);
      end
      if (w_fire) begin
         // low word at the beat address, high word 4 bytes up
         addr_q[wp] <= beat_addr;
         addr_q[wp_hi] <= beat_addr + `ADDR_WIDTH'(`LITE_DATA_WIDTH/8);
         data_q[wp] <= nasti_w_data.word[0];
         data_q[wp_hi] <= nasti_w_data.word[1];
         strb_q[wp] <= nasti_w_strb.half[0];
         strb_q[wp_hi] <= nasti_w_strb.half[1];
      end
   end

   // only full-width incr bursts are split correctly
   a_full_incr: assert property (@(posedge clk) disable iff (!rstn)
      aw_fire |-> nasti_aw_size == 3'd3 && nasti_aw_burst == burst_incr);

   // w beats stay inside the burst opened on aw, last where len says
   a_w_in_burst: assert property (@(posedge clk) disable iff (!rstn)
      w_fire |-> nasti_w_last == (beat_cnt == aw_len));

endmodule
`default_nettype wire

/* files.f */
+incdir+.
axi_pkg.sv
bridge_pkg.sv
burst_splitter.sv
resp_slot.sv
resp_merger.sv
nasti_lite_writer_top.sv
tb_lite_slave.sv
tb_nasti_lite_writer.sv

/* nasti_lite_writer_top.sv */
// top of the 64-bit nasti to 32-bit nasti-lite write bridge, the unit the testbench instantiates
`default_nettype none
`include "bridge_params.svh"

module nasti_lite_writer_top (
   input  wire                             clk,
   input  wire                             rstn,
   input  wire [`ID_WIDTH-1:0]             nasti_aw_id,
   input  wire [`ADDR_WIDTH-1:0]           nasti_aw_addr,
   input  wire [7:0]                       nasti_aw_len,
   input  wire [2:0]                       nasti_aw_size,
   input  wire axi_pkg::burst_t            nasti_aw_burst,
   input  wire [2:0]                       nasti_aw_prot,
   input  wire [3:0]                       nasti_aw_qos,
   input  wire [3:0]                       nasti_aw_region,
   input  wire                             nasti_aw_valid,
   output logic                            nasti_aw_ready,
   input  wire [`NASTI_DATA_WIDTH-1:0]     nasti_w_data,
   input  wire [`NASTI_DATA_WIDTH/8-1:0]   nasti_w_strb,
   input  wire                             nasti_w_last,
   input  wire                             nasti_w_valid,
   output logic                            nasti_w_ready,
   output logic [`ID_WIDTH-1:0]            nasti_b_id,
   output axi_pkg::resp_t                  nasti_b_resp,
   output logic                            nasti_b_valid,
   input  wire                             nasti_b_ready,
   output logic [`ID_WIDTH-1:0]            lite_aw_id,
   output logic [`ADDR_WIDTH-1:0]          lite_aw_addr,
   output logic [2:0]                      lite_aw_prot,
   output logic [3:0]                      lite_aw_qos,
   output logic [3:0]                      lite_aw_region,
   output logic                            lite_aw_valid,
   input  wire                             lite_aw_ready,
   output logic [`LITE_DATA_WIDTH-1:0]     lite_w_data,
   output logic [`LITE_DATA_WIDTH/8-1:0]   lite_w_strb,
   output logic                            lite_w_valid,
   input  wire                             lite_w_ready,
   input  wire [`ID_WIDTH-1:0]             lite_b_id,
   input  wire axi_pkg::resp_t             lite_b_resp,
   input  wire                             lite_b_valid,
   output logic                            lite_b_ready
);
   import axi_pkg::*;

   logic                                  aw_ok, xact_start, pieces_add, pieces_last;
   logic [`ID_WIDTH-1:0]                  xact_id;
   logic [`MAX_XACT-1:0]                  alloc, b_piece, slot_release, busy, slot_done;
   logic [`MAX_XACT-1:0][`ID_WIDTH-1:0]   slot_id;
   resp_t [`MAX_XACT-1:0]                 slot_resp;
   resp_t                                 b_resp;

   burst_splitter u_splitter (
      .clk, .rstn,
      .nasti_aw_id, .nasti_aw_addr, .nasti_aw_len, .nasti_aw_size, .nasti_aw_burst,
      .nasti_aw_prot, .nasti_aw_qos, .nasti_aw_region, .nasti_aw_valid, .nasti_aw_ready,
      .nasti_w_data, .nasti_w_strb, .nasti_w_last, .nasti_w_valid, .nasti_w_ready,
      .lite_aw_id, .lite_aw_addr, .lite_aw_prot, .lite_aw_qos, .lite_aw_region,
      .lite_aw_valid, .lite_aw_ready,
      .lite_w_data, .lite_w_strb, .lite_w_valid, .lite_w_ready,
      .aw_ok, .xact_start, .xact_id, .pieces_add, .pieces_last
   );

   // lite_aw_id holds the id of the burst whose beats are being taken
   for (genvar i = 0; i < `MAX_XACT; i++) begin : g_slot
      resp_slot u_slot (
         .clk, .rstn,
         .alloc(alloc[i]), .xact_id, .pieces_add, .pieces_id(lite_aw_id), .pieces_last,
         .b_piece(b_piece[i]), .b_resp, .slot_release(slot_release[i]),
         .busy(busy[i]), .slot_id(slot_id[i]), .slot_done(slot_done[i]),
         .slot_resp(slot_resp[i])
      );
   end

   resp_merger u_merger (
      .clk, .rstn,
      .nasti_aw_id, .xact_start,
      .busy, .slot_id, .slot_done, .slot_resp,
      .aw_ok, .alloc, .b_piece, .b_resp, .slot_release,
      .lite_b_id, .lite_b_resp, .lite_b_valid, .lite_b_ready,
      .nasti_b_id, .nasti_b_resp, .nasti_b_valid, .nasti_b_ready
   );

endmodule
`default_nettype wire

/* resp_merger.sv */
// slot allocation, lite b routing and nasti b return for the write bridge, used in the top
`default_nettype none
`include "bridge_params.svh"

module resp_merger (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire [`ID_WIDTH-1:0]                  nasti_aw_id,
   input  wire                                  xact_start,
   input  wire [`MAX_XACT-1:0]                  busy,
   input  wire [`MAX_XACT-1:0][`ID_WIDTH-1:0]   slot_id,
   input  wire [`MAX_XACT-1:0]                  slot_done,
   input  wire axi_pkg::resp_t [`MAX_XACT-1:0]  slot_resp,
   output logic                                 aw_ok,
   output logic [`MAX_XACT-1:0]                 alloc,
   output logic [`MAX_XACT-1:0]                 b_piece,
   output axi_pkg::resp_t                       b_resp,
   output logic [`MAX_XACT-1:0]                 slot_release,
   input  wire [`ID_WIDTH-1:0]                  lite_b_id,
   input  wire axi_pkg::resp_t                  lite_b_resp,
   input  wire                                  lite_b_valid,
   output logic                                 lite_b_ready,
   output logic [`ID_WIDTH-1:0]                 nasti_b_id,
   output axi_pkg::resp_t                       nasti_b_resp,
   output logic                                 nasti_b_valid,
   input  wire                                  nasti_b_ready
);
   import bridge_pkg::*;

   logic [`MAX_XACT-1:0] id_clash, id_hit, cand;
   logic                 has_free, has_cand, b_advance;
   slot_idx_t            free_idx, next_idx, cur_idx;

   assign b_advance = !nasti_b_valid || nasti_b_ready;
   assign lite_b_ready = b_advance;   // hold lite b while nasti b stalls
   assign b_resp = lite_b_resp;
   assign aw_ok = has_free && !(|id_clash);

   always_comb begin
      has_free = 1'b0;
      free_idx = '0;
      has_cand = 1'b0;
      next_idx = '0;
      // downward scan so the lowest index wins
      for (int i = `MAX_XACT-1; i >= 0; i--) begin
         id_clash[i] = busy[i] && slot_id[i] == nasti_aw_id;
         id_hit[i] = busy[i] && slot_id[i] == lite_b_id;
         cand[i] = slot_done[i] && !(nasti_b_valid && cur_idx == slot_idx_t'(i));
         if (!busy[i]) begin
            has_free = 1'b1;
            free_idx = slot_idx_t'(i);
         end
         if (cand[i]) begin
            has_cand = 1'b1;
            next_idx = slot_idx_t'(i);
         end
      end
      for (int i = 0; i < `MAX_XACT; i++) begin
         alloc[i] = xact_start && free_idx == slot_idx_t'(i);
         b_piece[i] = lite_b_valid && lite_b_ready && id_hit[i];
         slot_release[i] = nasti_b_valid && nasti_b_ready && cur_idx == slot_idx_t'(i);
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn)
         nasti_b_valid <= 1'b0;
      else if (b_advance)
         nasti_b_valid <= has_cand;
   end

   always_ff @(posedge clk) begin
      if (b_advance && has_cand) begin
         cur_idx <= next_idx;
         nasti_b_id <= slot_id[next_idx];
         nasti_b_resp <= slot_resp[next_idx];
      end
   end

   // aw id check keeps busy ids unique, so each lite b has one owner
   a_lite_b_owner: assert property (@(posedge clk) disable iff (!rstn)
      lite_b_valid && lite_b_ready |-> $onehot(id_hit));

endmodule
`default_nettype wire

/* resp_slot.sv */
// one outstanding burst: counts lite pieces issued and answered, instantiated per slot in the top
`default_nettype none
`include "bridge_params.svh"

module resp_slot (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    alloc,
   input  wire [`ID_WIDTH-1:0]    xact_id,
   input  wire                    pieces_add,
   input  wire [`ID_WIDTH-1:0]    pieces_id,
   input  wire                    pieces_last,
   input  wire                    b_piece,
   input  wire axi_pkg::resp_t    b_resp,
   input  wire                    slot_release,
   output logic                   busy,
   output logic [`ID_WIDTH-1:0]   slot_id,
   output logic                   slot_done,
   output axi_pkg::resp_t         slot_resp
);
   import axi_pkg::*;
   import bridge_pkg::*;

   piece_cnt_t issued, received;
   logic       last_seen;
   logic       own_beat;
   resp_t      resp_q;

   // ids of busy slots are unique, so a match is this burst
   assign own_beat = pieces_add && busy && pieces_id == slot_id;

   // the piece answered this cycle already counts
   assign slot_done = busy && last_seen && (received + piece_cnt_t'(b_piece)) == issued;
   assign slot_resp = b_piece ? merge_resp(resp_q, b_resp) : resp_q;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         busy <= 1'b0;
         last_seen <= 1'b0;
         issued <= '0;
         received <= '0;
      end else if (alloc) begin
         busy <= 1'b1;
         last_seen <= 1'b0;
         issued <= '0;
         received <= '0;
      end else if (slot_release) begin
         busy <= 1'b0;
      end else begin
         if (own_beat) begin
            issued <= issued + piece_cnt_t'(lite_per_beat);
            last_seen <= pieces_last;
         end
         if (b_piece)
            received <= received + piece_cnt_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         slot_id <= xact_id;
         resp_q <= resp_okay;
      end else if (b_piece) begin
         resp_q <= merge_resp(resp_q, b_resp);   // keep worst so far
      end
   end

   // lite b routed by the merger never outruns what the splitter issued
   a_recv_bound: assert property (@(posedge clk) disable iff (!rstn)
      busy |-> received <= issued);

endmodule
`default_nettype wire

/* tb_lite_slave.sv */
// behavioral nasti-lite slave for the bridge testbench, byte memory with random ready and an error window
`default_nettype none
`include "bridge_params.svh"

module tb_lite_slave #(
   parameter logic [`ADDR_WIDTH-1:0] err_lo = 16'h0080,
   parameter logic [`ADDR_WIDTH-1:0] err_hi = 16'h00bf
) (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire [`ID_WIDTH-1:0]          aw_id,
   input  wire [`ADDR_WIDTH-1:0]        aw_addr,
   input  wire                          aw_valid,
   output logic                         aw_ready,
   input  wire [`LITE_DATA_WIDTH-1:0]   w_data,
   input  wire [`LITE_DATA_WIDTH/8-1:0] w_strb,
   input  wire                          w_valid,
   output logic                         w_ready,
   output logic [`ID_WIDTH-1:0]         b_id,
   output axi_pkg::resp_t               b_resp,
   output logic                         b_valid,
   input  wire                          b_ready,
   input  wire                          b_hold
);
   timeunit 1ns;
   timeprecision 100ps;
   import axi_pkg::*;

   logic [7:0]                      mem [0:(1<<`ADDR_WIDTH)-1];
   logic [`ADDR_WIDTH-1:0]          addr_q [$];
   logic [`ID_WIDTH-1:0]            id_q [$];
   logic [`LITE_DATA_WIDTH-1:0]     data_q [$];
   logic [`LITE_DATA_WIDTH/8-1:0]   strb_q [$];
   logic [`ID_WIDTH-1:0]            bid_q [$];
   resp_t                           bresp_q [$];

   always @(posedge clk or negedge rstn) begin : slave_proc
      logic [`ADDR_WIDTH-1:0]        a;
      logic [`LITE_DATA_WIDTH-1:0]   d;
      logic [`LITE_DATA_WIDTH/8-1:0] s;
      if (!rstn) begin
         aw_ready <= 1'b0;
         w_ready <= 1'b0;
         b_valid <= 1'b0;
         b_id <= '0;
         b_resp <= resp_okay;
         addr_q.delete();
         id_q.delete();
         data_q.delete();
         strb_q.delete();
         bid_q.delete();
         bresp_q.delete();
         for (int i = 0; i < (1 << `ADDR_WIDTH); i++)
            mem[i] = 8'(i) ^ 8'(i >> 8);   // fill from the whole address
      end else begin
         aw_ready <= ($urandom % 4) != 0;
         w_ready <= ($urandom % 4) != 0;
         if (aw_valid && aw_ready) begin
            addr_q.push_back(aw_addr);
            id_q.push_back(aw_id);
         end
         if (w_valid && w_ready) begin
            data_q.push_back(w_data);
            strb_q.push_back(w_strb);
         end
         // pair address with data, then queue the answer
         while (addr_q.size() != 0 && data_q.size() != 0) begin
            a = addr_q.pop_front();
            d = data_q.pop_front();
            s = strb_q.pop_front();
            for (int i = 0; i < `LITE_DATA_WIDTH/8; i++)
               if (s[i])
                  mem[a + `ADDR_WIDTH'(i)] = d[8*i +: 8];
            bid_q.push_back(id_q.pop_front());
            bresp_q.push_back((a >= err_lo && a <= err_hi) ? resp_slverr : resp_okay);
         end
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
            bid_q.delete(0);
            bresp_q.delete(0);
         end
         // valid stays up once raised
         if ((!b_valid || b_ready) && bid_q.size() != 0 && !b_hold && ($urandom % 2) == 0) begin
            b_valid <= 1'b1;
            b_id <= bid_q[0];
            b_resp <= bresp_q[0];
         end
      end
   end

endmodule
`default_nettype wire

/* tb_nasti_lite_writer.sv */
// testbench of the nasti to nasti-lite write bridge, runs a burst table against a lite slave model
`default_nettype none
`include "bridge_params.svh"

module tb_nasti_lite_writer;
   timeunit 1ns;
   timeprecision 100ps;
   import axi_pkg::*;

   typedef struct packed {
      logic [`ID_WIDTH-1:0]   id;
      logic [`ADDR_WIDTH-1:0] addr;
      logic [7:0]             len;
      logic [7:0]             strb;   // same strobe on every beat
      logic                   hold;   // slave keeps lite b back
   } burst_rec_t;

   localparam int n_burst = 13;
   localparam burst_rec_t bursts [n_burst] = '{
      '{2'd0, 16'h0000, 8'd0,   8'hff, 1'b0},
      '{2'd1, 16'h0040, 8'd3,   8'hff, 1'b0},
      '{2'd2, 16'h0078, 8'd1,   8'hff, 1'b0},   // crosses into error window
      '{2'd3, 16'h0100, 8'd7,   8'h3c, 1'b0},
      '{2'd0, 16'h00b8, 8'd0,   8'hf0, 1'b0},
      '{2'd1, 16'h0400, 8'd255, 8'hff, 1'b0},
      '{2'd0, 16'h1000, 8'd1,   8'hff, 1'b1},   // four held bursts fill every slot
      '{2'd1, 16'h1010, 8'd1,   8'h5a, 1'b1},
      '{2'd2, 16'h0090, 8'd0,   8'hff, 1'b1},
      '{2'd3, 16'h1020, 8'd2,   8'hff, 1'b1},
      '{2'd0, 16'h1040, 8'd1,   8'hff, 1'b0},   // reused id waits at aw
      '{2'd0, 16'h1050, 8'd0,   8'hff, 1'b0},
      '{2'd2, 16'h2000, 8'd15,  8'hc3, 1'b0}
   };

   logic                           clk = 1'b0;
   logic                           rstn;
   logic [`ID_WIDTH-1:0]           nasti_aw_id, nasti_b_id, lite_aw_id, lite_b_id;
   logic [`ADDR_WIDTH-1:0]         nasti_aw_addr, lite_aw_addr;
   logic [7:0]                     nasti_aw_len;
   logic [2:0]                     nasti_aw_size, nasti_aw_prot, lite_aw_prot;
   burst_t                         nasti_aw_burst;
   logic [3:0]                     nasti_aw_qos, nasti_aw_region, lite_aw_qos, lite_aw_region;
   logic                           nasti_aw_valid, nasti_aw_ready, lite_aw_valid, lite_aw_ready;
   logic [`NASTI_DATA_WIDTH-1:0]   nasti_w_data;
   logic [`NASTI_DATA_WIDTH/8-1:0] nasti_w_strb;
   logic                           nasti_w_last, nasti_w_valid, nasti_w_ready;
   logic [`LITE_DATA_WIDTH-1:0]    lite_w_data;
   logic [`LITE_DATA_WIDTH/8-1:0]  lite_w_strb;
   logic                           lite_w_valid, lite_w_ready;
   resp_t                          nasti_b_resp, lite_b_resp;
   logic                           nasti_b_valid, nasti_b_ready, lite_b_valid, lite_b_ready;
   logic                           b_hold;

   int                             errors = 0;
   int                             checks = 0;
   int                             b_count = 0;
   int                             max_pend = 0;
   logic [`ADDR_WIDTH-1:0]         exp_aw_addr [$];
   logic [12:0]                    exp_aw_attr [$];   // id, prot, qos, region
   logic [`LITE_DATA_WIDTH-1:0]    exp_w_data [$];
   logic [`LITE_DATA_WIDTH/8-1:0]  exp_w_strb [$];
   logic [`ID_WIDTH-1:0]           pend_id [$];
   resp_t                          pend_resp [$];
   logic [7:0]                     ref_mem [0:(1<<`ADDR_WIDTH)-1];

   nasti_lite_writer_top UUT (.*);

   tb_lite_slave u_slave (
      .clk, .rstn,
      .aw_id(lite_aw_id), .aw_addr(lite_aw_addr), .aw_valid(lite_aw_valid),
      .aw_ready(lite_aw_ready),
      .w_data(lite_w_data), .w_strb(lite_w_strb), .w_valid(lite_w_valid),
      .w_ready(lite_w_ready),
      .b_id(lite_b_id), .b_resp(lite_b_resp), .b_valid(lite_b_valid),
      .b_ready(lite_b_ready), .b_hold
   );

   always #50 clk = ~clk;

   always @(posedge clk)
      nasti_b_ready <= ($urandom % 3) != 0;   // stalls about a third of the cycles

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // slverr when any word of the burst lands in 0x0080..0x00bf
   function automatic resp_t expected_resp(input burst_rec_t b);
      logic [`ADDR_WIDTH-1:0] a;
      resp_t                  r;
      r = resp_okay;
      a = b.addr;
      for (int k = 0; k < int'(b.len) + 1; k++) begin
         if ((a >= 16'h0080 && a <= 16'h00bf) || (a + 16'd4 >= 16'h0080 && a + 16'd4 <= 16'h00bf))
            r = resp_slverr;
         a = a + 16'd8;
      end
      return r;
   endfunction

   task automatic send_burst(input burst_rec_t b);
      beat_u                  beat;
      logic [`ADDR_WIDTH-1:0] a;
      int                     same_id;
      same_id = 0;
      a = b.addr;
      if (b.hold && !b_hold)
         while (pend_id.size() != 0)
            @(posedge clk);
      b_hold <= b.hold;
      nasti_aw_id <= b.id;
      nasti_aw_addr <= b.addr;
      nasti_aw_len <= b.len;
      nasti_aw_prot <= {1'b0, b.id};
      nasti_aw_qos <= b.len[3:0];
      nasti_aw_region <= ~{2'b00, b.id};
      nasti_aw_valid <= 1'b1;
      @(posedge clk);
      while (!nasti_aw_ready)
         @(posedge clk);
      nasti_aw_valid <= 1'b0;
      foreach (pend_id[i])
         if (pend_id[i] == b.id)
            same_id++;
      compare("open bursts with reused id", 64'(same_id), 64'd0);
      pend_id.push_back(b.id);
      pend_resp.push_back(expected_resp(b));
      if (pend_id.size() > max_pend)
         max_pend = pend_id.size();
      for (int k = 0; k <= int'(b.len); k++) begin
         beat.whole = {$urandom, $urandom};
         nasti_w_data <= beat.whole;
         nasti_w_strb <= b.strb;
         nasti_w_last <= (k == int'(b.len));
         nasti_w_valid <= 1'b1;
         exp_aw_addr.push_back(a);
         exp_aw_addr.push_back(a + 16'd4);
         exp_aw_attr.push_back({b.id, 1'b0, b.id, b.len[3:0], ~{2'b00, b.id}});
         exp_aw_attr.push_back({b.id, 1'b0, b.id, b.len[3:0], ~{2'b00, b.id}});
         exp_w_data.push_back(beat.whole[31:0]);
         exp_w_data.push_back(beat.whole[63:32]);
         exp_w_strb.push_back(b.strb[3:0]);
         exp_w_strb.push_back(b.strb[7:4]);
         for (int j = 0; j < 8; j++)
            if (b.strb[j])
               ref_mem[a + `ADDR_WIDTH'(j)] = beat.whole[8*j +: 8];
         @(posedge clk);
         while (!nasti_w_ready)
            @(posedge clk);
         a = a + 16'd8;
      end
      nasti_w_valid <= 1'b0;
      nasti_w_last <= 1'b0;
   endtask

   always @(posedge clk) begin : monitor
      int hit;
      if (rstn && lite_aw_valid && lite_aw_ready) begin
         if (exp_aw_addr.size() == 0) begin
            errors++;
            $display("lite AW write at %0d ns with no beat left to split", $time);
         end else begin
            compare("lite_aw_addr", 64'(lite_aw_addr), 64'(exp_aw_addr.pop_front()));
            compare("lite_aw_id/prot/qos/region",
               64'({lite_aw_id, lite_aw_prot, lite_aw_qos, lite_aw_region}),
               64'(exp_aw_attr.pop_front()));
         end
      end
      if (rstn && lite_w_valid && lite_w_ready) begin
         if (exp_w_data.size() == 0) begin
            errors++;
            $display("lite W data at %0d ns with no beat left to split", $time);
         end else begin
            compare("lite_w_data", 64'(lite_w_data), 64'(exp_w_data.pop_front()));
            compare("lite_w_strb", 64'(lite_w_strb), 64'(exp_w_strb.pop_front()));
         end
      end
      // lite b waits while nasti b is stalled
      if (rstn && nasti_b_valid && !nasti_b_ready)
         compare("lite_b_ready", 64'(lite_b_ready), 64'd0);
      if (rstn && nasti_b_valid && nasti_b_ready) begin
         b_count++;
         hit = -1;
         foreach (pend_id[i])
            if (hit < 0 && pend_id[i] == nasti_b_id)
               hit = i;
         if (hit < 0) begin
            errors++;
            $display("B response for id %0d at %0d ns matches no open burst", nasti_b_id, $time);
         end else begin
            compare("nasti_b_resp", 64'(nasti_b_resp), 64'(pend_resp[hit]));
            pend_id.delete(hit);
            pend_resp.delete(hit);
         end
      end
   end

   task automatic finish_run();
      $display("checks: %0d, errors: %0d, b responses: %0d", checks, errors, b_count);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   initial begin : main
      void'($urandom(32'hb0e20930));
      rstn = 1'b0;
      b_hold = 1'b0;
      nasti_aw_id = '0;
      nasti_aw_addr = '0;
      nasti_aw_len = '0;
      nasti_aw_size = 3'd3;
      nasti_aw_burst = burst_incr;
      nasti_aw_prot = '0;
      nasti_aw_qos = '0;
      nasti_aw_region = '0;
      nasti_aw_valid = 1'b0;
      nasti_w_data = '0;
      nasti_w_strb = '0;
      nasti_w_last = 1'b0;
      nasti_w_valid = 1'b0;
      nasti_b_ready = 1'b0;
      for (int a = 0; a < (1 << `ADDR_WIDTH); a++)
         ref_mem[a] = 8'(a) ^ 8'(a >> 8);
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      for (int i = 0; i < n_burst; i++)
         send_burst(bursts[i]);
      while (pend_id.size() != 0)
         @(posedge clk);
      compare("b responses", 64'(b_count), 64'(n_burst));
      compare("peak open bursts", 64'(max_pend), 64'(`MAX_XACT));
      compare("lite aw left over", 64'(exp_aw_addr.size()), 64'd0);
      compare("lite w left over", 64'(exp_w_data.size()), 64'd0);
      for (int a = 0; a < (1 << `ADDR_WIDTH); a++)
         if (u_slave.mem[a] !== ref_mem[a])
            compare($sformatf("mem[%04h]", a), 64'(u_slave.mem[a]), 64'(ref_mem[a]));
      finish_run();
   end

   initial begin : watchdog
      int beats;
      beats = 0;
      foreach (bursts[i])
         beats += int'(bursts[i].len) + 1;
      repeat (40 * beats + 500) @(posedge clk);
      errors++;
      $display("timeout, bursts still open after %0d cycles", 40 * beats + 500);
      finish_run();
   end

endmodule
`default_nettype wire
